/* verilog/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// first fetch address after reset.
`define RV_RESET_PC 32'h0000_0000

// the only CSR that holds state.
`define RV_CSR_MSCRATCH 12'h340

// architectural integer registers, x0 included.
`define RV_NUM_REGS 32

`endif

/* verilog/rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    typedef enum logic [6:0] {
        OPC_LW    = 7'b0000011,
        OPC_SW    = 7'b0100011,
        OPC_RTYPE = 7'b0110011,
        OPC_ITYPE = 7'b0010011,
        OPC_JAL   = 7'b1101111,
        OPC_BEQ   = 7'b1100011,
        OPC_JALR  = 7'b1100111,
        OPC_AUIPC = 7'b0010111,
        OPC_LUI   = 7'b0110111,
        OPC_CSR   = 7'b1110011
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,
        ALU_SUB   = 2'b01,
        ALU_FUNCT = 2'b10
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_A_PC     = 2'b00,
        SRC_A_REG    = 2'b01,
        SRC_A_OLD_PC = 2'b10,
        SRC_A_ZERO   = 2'b11
    } src_a_t;

    typedef enum logic [1:0] {
        SRC_B_REG  = 2'b00,
        SRC_B_FOUR = 2'b01,
        SRC_B_IMM  = 2'b10
    } src_b_t;

    typedef enum logic [1:0] {
        WB_ALU_OUT  = 2'b00,
        WB_MEM_DATA = 2'b01,
        WB_CSR_OLD  = 2'b10
    } wb_sel_t;

    typedef enum logic [3:0] {
        ST_FETCH      = 4'b0000,
        ST_DECODE     = 4'b0001,
        ST_MEMADR     = 4'b0010,
        ST_MEMREAD    = 4'b0011,
        ST_MEMWB      = 4'b0100,
        ST_MEMWRITE   = 4'b0101,
        ST_EXECUTER   = 4'b0110,
        ST_ALUWB      = 4'b0111,
        ST_EXECUTEI   = 4'b1000,
        ST_JAL        = 4'b1001,
        ST_BEQ        = 4'b1010,
        ST_JALR       = 4'b1011,
        ST_AUIPC      = 4'b1100,
        ST_LUI        = 4'b1101,
        ST_JALR_PC    = 4'b1110,
        ST_EXECUTECSR = 4'b1111
    } ctrl_state_t;

    typedef struct packed {
        logic    lord;
        logic    pc_write;
        logic    ir_write;
        logic    pc_source;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_immediate;
        logic    pc_write_cond;
        logic    csr_write;
        alu_op_t alu_op;
        src_a_t  src_a;
        src_b_t  src_b;
        wb_sel_t wb_sel;
    } ctrl_t;

endpackage

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_t    alu_op,
    input  logic       is_immediate,
    input  logic [2:0] funct3,
    input  logic       funct7_5,
    output word_t      result,
    output logic       zero
);

    typedef enum logic [2:0] {
        FN_ADD,
        FN_SUB,
        FN_AND,
        FN_OR,
        FN_XOR,
        FN_SLT,
        FN_SLL,
        FN_SRL
    } alu_fn_t;

    alu_fn_t fn;

    always_comb begin
        fn = FN_ADD;
        case (alu_op)
            ALU_ADD: fn = FN_ADD;
            ALU_SUB: fn = FN_SUB;
            default: begin
                case (funct3)
                    // immediates have no subtract, so bit 30 only counts for R-type.
                    3'b000:  fn = (!is_immediate && funct7_5) ? FN_SUB : FN_ADD;
                    3'b001:  fn = FN_SLL;
                    3'b010:  fn = FN_SLT;
                    3'b100:  fn = FN_XOR;
                    3'b101:  fn = FN_SRL;
                    3'b110:  fn = FN_OR;
                    3'b111:  fn = FN_AND;
                    default: fn = FN_ADD;
                endcase
            end
        endcase
    end

    always_comb begin
        case (fn)
            FN_SUB:  result = a - b;
            FN_AND:  result = a & b;
            FN_OR:   result = a | b;
            FN_XOR:  result = a ^ b;
            FN_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            FN_SLL:  result = a << b[4:0];
            FN_SRL:  result = a >> b[4:0];
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* verilog/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen import rv_pkg::*; (
    input  word_t instr,
    output word_t imm
);

    opcode_t opcode;

    assign opcode = opcode_t'(instr[6:0]);

    always_comb begin
        case (opcode)
            OPC_SW: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_BEQ: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {instr[31:12], 12'b0};
            end
            OPC_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                // loads, jalr, ALU immediates and anything else use the I format.
                imm = {{20{instr[31]}}, instr[31:20]};
            end
        endcase
    end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module register_file import rv_pkg::*; (
    input  logic      clk,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  word_t     wdata,
    input  logic      write_en,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [0:`RV_NUM_REGS-1];

    // x0 is never written, so its entry is masked on the read side.
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (write_en && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

endmodule

/* verilog/csr_unit.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module csr_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      write_en,
    input  csr_addr_t addr,
    input  word_t     wdata,
    output word_t     old_value
);

    word_t mscratch;
    logic  hit;

    assign hit = (addr == `RV_CSR_MSCRATCH);

    // unimplemented CSRs read as zero.
    assign old_value = hit ? mscratch : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch <= '0;
        end else if (write_en && hit) begin
            mscratch <= wdata;
        end
    end

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ps

module control_unit import rv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  opcode_t opcode,
    output ctrl_t   ctrl
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = ST_FETCH;
        case (state)
            ST_FETCH: begin
                next_state = ST_DECODE;
            end
            ST_DECODE: begin
                // an opcode outside the supported set falls back to fetch.
                case (opcode)
                    OPC_LW:    next_state = ST_MEMADR;
                    OPC_SW:    next_state = ST_MEMADR;
                    OPC_RTYPE: next_state = ST_EXECUTER;
                    OPC_ITYPE: next_state = ST_EXECUTEI;
                    OPC_JAL:   next_state = ST_JAL;
                    OPC_BEQ:   next_state = ST_BEQ;
                    OPC_AUIPC: next_state = ST_AUIPC;
                    OPC_LUI:   next_state = ST_LUI;
                    OPC_JALR:  next_state = ST_JALR_PC;
                    OPC_CSR:   next_state = ST_EXECUTECSR;
                    default:   next_state = ST_FETCH;
                endcase
            end
            ST_MEMADR: begin
                if (opcode == OPC_LW) begin
                    next_state = ST_MEMREAD;
                end else begin
                    next_state = ST_MEMWRITE;
                end
            end
            ST_MEMREAD:    next_state = ST_MEMWB;
            ST_MEMWB:      next_state = ST_FETCH;
            ST_MEMWRITE:   next_state = ST_FETCH;
            ST_EXECUTER:   next_state = ST_ALUWB;
            ST_EXECUTEI:   next_state = ST_ALUWB;
            ST_ALUWB:      next_state = ST_FETCH;
            ST_JAL:        next_state = ST_ALUWB;
            ST_BEQ:        next_state = ST_FETCH;
            ST_JALR_PC:    next_state = ST_JALR;
            ST_JALR:       next_state = ST_ALUWB;
            ST_AUIPC:      next_state = ST_ALUWB;
            ST_LUI:        next_state = ST_ALUWB;
            ST_EXECUTECSR: next_state = ST_FETCH;
            default:       next_state = ST_FETCH;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.src_a  = SRC_A_PC;
        ctrl.src_b  = SRC_B_REG;
        ctrl.wb_sel = WB_ALU_OUT;

        case (state)
            ST_FETCH: begin
                ctrl.mem_read = 1'b1;
                ctrl.ir_write = 1'b1;
                ctrl.src_b    = SRC_B_FOUR;
                ctrl.pc_write = 1'b1;
            end
            ST_DECODE: begin
                // branch and jump target is formed here, before the opcode is known.
                ctrl.src_a = SRC_A_OLD_PC;
                ctrl.src_b = SRC_B_IMM;
            end
            ST_MEMADR: begin
                ctrl.src_a = SRC_A_REG;
                ctrl.src_b = SRC_B_IMM;
            end
            ST_MEMREAD: begin
                ctrl.mem_read = 1'b1;
                ctrl.lord     = 1'b1;
            end
            ST_MEMWB: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_MEM_DATA;
            end
            ST_MEMWRITE: begin
                ctrl.mem_write = 1'b1;
                ctrl.lord      = 1'b1;
            end
            ST_EXECUTER: begin
                ctrl.src_a  = SRC_A_REG;
                ctrl.alu_op = ALU_FUNCT;
            end
            ST_EXECUTEI: begin
                ctrl.src_a        = SRC_A_REG;
                ctrl.src_b        = SRC_B_IMM;
                ctrl.alu_op       = ALU_FUNCT;
                ctrl.is_immediate = 1'b1;
            end
            ST_ALUWB: begin
                ctrl.reg_write = 1'b1;
            end
            ST_JAL: begin
                // the link value is computed while the PC takes the stored target.
                ctrl.src_a     = SRC_A_OLD_PC;
                ctrl.src_b     = SRC_B_FOUR;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = 1'b1;
            end
            ST_BEQ: begin
                ctrl.src_a         = SRC_A_REG;
                ctrl.alu_op        = ALU_SUB;
                ctrl.pc_write_cond = 1'b1;
                ctrl.pc_source     = 1'b1;
            end
            ST_JALR_PC: begin
                ctrl.src_a = SRC_A_REG;
                ctrl.src_b = SRC_B_IMM;
            end
            ST_JALR: begin
                ctrl.src_a     = SRC_A_OLD_PC;
                ctrl.src_b     = SRC_B_FOUR;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = 1'b1;
            end
            ST_AUIPC: begin
                ctrl.src_a = SRC_A_OLD_PC;
                ctrl.src_b = SRC_B_IMM;
            end
            ST_LUI: begin
                ctrl.src_a = SRC_A_ZERO;
                ctrl.src_b = SRC_B_IMM;
            end
            ST_EXECUTECSR: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_CSR_OLD;
                ctrl.csr_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

/* verilog/rv_multicycle_core.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_multicycle_core import rv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    output word_t mem_addr,
    output word_t mem_wdata,
    input  word_t mem_rdata,
    output logic  mem_read,
    output logic  mem_write
);

    ctrl_t   ctrl;
    opcode_t opcode;

    word_t pc;
    word_t ir;
    word_t old_pc;
    word_t mdr;
    word_t reg_a;
    word_t reg_b;
    word_t alu_out;

    word_t imm;
    word_t src_a_val;
    word_t src_b_val;
    word_t alu_result;
    word_t rdata1;
    word_t rdata2;
    word_t csr_old;
    word_t wb_data;
    word_t pc_next;
    logic  alu_zero;
    logic  pc_en;

    assign opcode = opcode_t'(ir[6:0]);

    control_unit u_control (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    imm_gen u_imm_gen (
        .instr (ir),
        .imm   (imm)
    );

    always_comb begin
        case (ctrl.src_a)
            SRC_A_REG:    src_a_val = reg_a;
            SRC_A_OLD_PC: src_a_val = old_pc;
            SRC_A_ZERO:   src_a_val = '0;
            default:      src_a_val = pc;
        endcase
    end

    always_comb begin
        case (ctrl.src_b)
            SRC_B_FOUR: src_b_val = 32'd4;
            SRC_B_IMM:  src_b_val = imm;
            default:    src_b_val = reg_b;
        endcase
    end

    alu u_alu (
        .a            (src_a_val),
        .b            (src_b_val),
        .alu_op       (ctrl.alu_op),
        .is_immediate (ctrl.is_immediate),
        .funct3       (ir[14:12]),
        .funct7_5     (ir[30]),
        .result       (alu_result),
        .zero         (alu_zero)
    );

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM_DATA: wb_data = mdr;
            WB_CSR_OLD:  wb_data = csr_old;
            default:     wb_data = alu_out;
        endcase
    end

    register_file u_regs (
        .clk      (clk),
        .rs1      (ir[19:15]),
        .rs2      (ir[24:20]),
        .rd       (ir[11:7]),
        .wdata    (wb_data),
        .write_en (ctrl.reg_write),
        .rdata1   (rdata1),
        .rdata2   (rdata2)
    );

    csr_unit u_csr (
        .clk       (clk),
        .reset     (reset),
        .write_en  (ctrl.csr_write),
        .addr      (ir[31:20]),
        .wdata     (reg_a),
        .old_value (csr_old)
    );

    // stored targets are always even except for jalr, whose low bit must be dropped.
    assign pc_next = ctrl.pc_source ? {alu_out[31:1], 1'b0} : alu_result;
    assign pc_en   = ctrl.pc_write | (ctrl.pc_write_cond & alu_zero);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            ir     <= mem_rdata;
            old_pc <= pc;
        end
        if (ctrl.mem_read && ctrl.lord) begin
            mdr <= mem_rdata;
        end
        reg_a   <= rdata1;
        reg_b   <= rdata2;
        alu_out <= alu_result;
    end

    assign mem_addr  = ctrl.lord ? alu_out : pc;
    assign mem_wdata = reg_b;
    assign mem_read  = ctrl.mem_read;
    assign mem_write = ctrl.mem_write;

endmodule

/* sim/rv_multicycle_core_chk.sv */
`timescale 1ns/1ps

module rv_multicycle_core_chk import rv_pkg::*; (
    input logic        clk,
    input logic        reset,
    input ctrl_state_t state,
    input ctrl_t       ctrl
);

    // the unified memory port carries one access per cycle.
    mem_strobes_exclusive: assert property (@(posedge clk)
        !(ctrl.mem_read && ctrl.mem_write))
        else $error("mem_read and mem_write are high in the same cycle");

    fetch_after_reset: assert property (@(posedge clk)
        reset |=> (state == ST_FETCH))
        else $error("state is not FETCH after reset");

    // a conditional PC update always takes the stored target.
    cond_write_uses_target: assert property (@(posedge clk)
        ctrl.pc_write_cond |-> ctrl.pc_source)
        else $error("pc_write_cond without pc_source");

    no_early_reg_write: assert property (@(posedge clk)
        ctrl.reg_write |-> ((state != ST_FETCH) && (state != ST_DECODE)))
        else $error("reg_write during FETCH or DECODE");

endmodule

bind control_unit rv_multicycle_core_chk u_chk (
    .clk   (clk),
    .reset (reset),
    .state (state),
    .ctrl  (ctrl)
);

/* sim/rv_multicycle_core_tb.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_multicycle_core_tb import rv_pkg::*; ();

    localparam int MEM_WORDS    = 1024;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    // instructions executed by the six programs, in test order.
    localparam int INSTR_TOTAL  = 36 + 6 + 11 + 11 + 13 + 8;
    localparam int TIMEOUT_CYCLES = 2 * (5 * INSTR_TOTAL + NUM_TESTS * RESET_CYCLES);

    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    logic  clk;
    logic  reset;
    word_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_read;
    logic  mem_write;

    word_t mem   [0:MEM_WORDS-1];
    word_t image [0:MEM_WORDS-1];
    word_t emit_pc;
    word_t store_addr_q [$];
    word_t store_data_q [$];
    word_t lfsr_state    = 32'h0c11_a0e0;
    int    error_count   = 0;
    int    timeout_count = 0;
    int    cycle_count   = 0;

    rv_multicycle_core u_dut (
        .clk       (clk),
        .reset     (reset),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // read data is set up half a cycle ahead of the edge that captures it.
    always @(negedge clk) begin
        if (mem_read) begin
            mem_rdata = mem[mem_addr[11:2]];
        end
    end

    always @(posedge clk) begin
        if (mem_write === 1'b1) begin
            mem[mem_addr[11:2]] = mem_wdata;
            store_addr_q.push_back(mem_addr);
            store_data_q.push_back(mem_wdata);
        end
    end

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output word_t value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // order is add, sub, and, or, xor, slt, sll, srl.
    function automatic logic [2:0] op_funct3(input int k);
        case (k)
            2:       return 3'b111;
            3:       return 3'b110;
            4:       return 3'b100;
            5:       return 3'b010;
            6:       return 3'b001;
            7:       return 3'b101;
            default: return 3'b000;
        endcase
    endfunction

    function automatic word_t alu_expect(input int k, input word_t a, input word_t b);
        case (k)
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6:       return a << b[4:0];
            7:       return a >> b[4:0];
            default: return a + b;
        endcase
    endfunction

    task automatic clear_image();
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i[9:0]] = 32'h5a5a_0000 ^ (i * 32'h0001_0003);
        end
        emit_pc = `RV_RESET_PC;
    endtask

    task automatic emit(input word_t instr);
        image[emit_pc[11:2]] = instr;
        emit_pc = emit_pc + 32'd4;
    endtask

    task automatic load_const(input reg_addr_t rd, input word_t value);
        logic [19:0] upper;
        // addi sign-extends its immediate, so the upper part absorbs bit 11.
        upper = value[31:12] + {19'b0, value[11]};
        emit(u_type(upper, rd, OP_LUI));
        emit(i_type(value[11:0], rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic reset_and_load();
        @(negedge clk);
        reset = 1'b1;
        // two edges in reset park the core in fetch before memory changes.
        repeat (2) @(negedge clk);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i[9:0]] = image[i[9:0]];
        end
        store_addr_q.delete();
        store_data_q.delete();
        repeat (RESET_CYCLES - 2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic wait_for_stores(input int n);
        while (store_addr_q.size() < n) begin
            @(negedge clk);
        end
    endtask

    task automatic check_store(input int idx, input word_t exp_addr, input word_t exp_data,
                               input string what);
        assert (store_addr_q[idx] == exp_addr) else begin
            error_count++;
            $display("ERROR at %0t: %s store %0d address %h, expected %h",
                     $time, what, idx, store_addr_q[idx], exp_addr);
        end
        assert (store_data_q[idx] == exp_data) else begin
            error_count++;
            $display("ERROR at %0t: %s store %0d data %h, expected %h",
                     $time, what, idx, store_data_q[idx], exp_data);
        end
    endtask

    task automatic exercise_alu();
        word_t       a;
        word_t       b;
        word_t       bits;
        logic [11:0] imm;
        logic [11:0] off;
        word_t       expect_q [$];
        clear_image();
        draw_bits(32, a);
        draw_bits(32, b);
        off = 12'd0;
        emit(i_type(12'h400, 5'd0, 3'b000, 5'd1, OP_IMM));
        load_const(5'd3, a);
        load_const(5'd4, b);
        for (int k = 0; k < 8; k++) begin
            emit(r_type((k == 1) ? 7'b0100000 : 7'b0000000, 5'd4, 5'd3, op_funct3(k), 5'd5));
            emit(s_type(off, 5'd5, 5'd1));
            off = off + 12'd4;
            expect_q.push_back(alu_expect(k, a, b));
        end
        // the I forms have no subtract.
        for (int k = 0; k < 8; k++) begin
            if (k != 1) begin
                draw_bits(12, bits);
                imm = (k >= 6) ? {7'b0, bits[4:0]} : bits[11:0];
                emit(i_type(imm, 5'd3, op_funct3(k), 5'd5, OP_IMM));
                emit(s_type(off, 5'd5, 5'd1));
                off = off + 12'd4;
                expect_q.push_back(alu_expect(k, a, {{20{imm[11]}}, imm}));
            end
        end
        emit(j_type(21'd0, 5'd0));
        reset_and_load();
        wait_for_stores(expect_q.size());
        for (int i = 0; i < expect_q.size(); i++) begin
            check_store(i, 32'h400 + 4 * i, expect_q[i], "alu");
        end
    endtask

    task automatic round_trip_memory();
        word_t value;
        word_t data_addr;
        clear_image();
        draw_bits(32, value);
        data_addr = 32'h508;
        image[data_addr[11:2]] = value;
        emit(i_type(12'h500, 5'd0, 3'b000, 5'd1, OP_IMM));
        emit(i_type(12'd8, 5'd1, 3'b010, 5'd2, OP_LOAD));
        emit(i_type(12'h600, 5'd0, 3'b000, 5'd6, OP_IMM));
        emit(s_type(12'd20, 5'd2, 5'd6));
        emit(s_type(12'hffc, 5'd2, 5'd6));
        emit(j_type(21'd0, 5'd0));
        reset_and_load();
        wait_for_stores(2);
        check_store(0, 32'h614, value, "lw then sw");
        check_store(1, 32'h5fc, value, "sw with negative offset");
    endtask

    task automatic branch_on_equal();
        clear_image();
        emit(i_type(12'h400, 5'd0, 3'b000, 5'd1, OP_IMM));
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd2, OP_IMM));
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd3, OP_IMM));
        emit(i_type(12'd7, 5'd0, 3'b000, 5'd4, OP_IMM));
        emit(b_type(13'd12, 5'd3, 5'd2));
        emit(i_type(12'h011, 5'd0, 3'b000, 5'd5, OP_IMM));
        emit(s_type(12'd0, 5'd5, 5'd1));
        emit(b_type(13'd12, 5'd4, 5'd2));
        emit(i_type(12'h022, 5'd0, 3'b000, 5'd6, OP_IMM));
        emit(s_type(12'd4, 5'd6, 5'd1));
        emit(i_type(12'h033, 5'd0, 3'b000, 5'd7, OP_IMM));
        emit(s_type(12'd8, 5'd7, 5'd1));
        emit(j_type(21'd0, 5'd0));
        reset_and_load();
        wait_for_stores(2);
        check_store(0, 32'h404, 32'h22, "beq not taken");
        check_store(1, 32'h408, 32'h33, "beq fall through");
    endtask

    task automatic jumps_and_upper();
        word_t       bits;
        word_t       jal_pc;
        word_t       jalr_pc;
        word_t       auipc_pc;
        logic [19:0] upper_lui;
        logic [19:0] upper_auipc;
        clear_image();
        draw_bits(20, bits);
        upper_lui = bits[19:0];
        draw_bits(20, bits);
        upper_auipc = bits[19:0];
        emit(i_type(12'h400, 5'd0, 3'b000, 5'd1, OP_IMM));
        jal_pc = emit_pc;
        emit(j_type(21'd12, 5'd2));
        emit(i_type(12'h055, 5'd0, 3'b000, 5'd9, OP_IMM));
        emit(s_type(12'd0, 5'd9, 5'd1));
        emit(s_type(12'd0, 5'd2, 5'd1));
        emit(i_type(12'd35, 5'd0, 3'b000, 5'd3, OP_IMM));
        jalr_pc = emit_pc;
        // 35 plus 6 is odd, so landing on 40 needs bit 0 cleared.
        emit(i_type(12'd6, 5'd3, 3'b000, 5'd4, OP_JALR));
        emit(i_type(12'h066, 5'd0, 3'b000, 5'd9, OP_IMM));
        emit(s_type(12'd4, 5'd9, 5'd1));
        emit(s_type(12'd4, 5'd9, 5'd1));
        emit(s_type(12'd4, 5'd4, 5'd1));
        emit(u_type(upper_lui, 5'd5, OP_LUI));
        emit(s_type(12'd8, 5'd5, 5'd1));
        auipc_pc = emit_pc;
        emit(u_type(upper_auipc, 5'd6, OP_AUIPC));
        emit(s_type(12'd12, 5'd6, 5'd1));
        emit(j_type(21'd0, 5'd0));
        reset_and_load();
        wait_for_stores(4);
        check_store(0, 32'h400, jal_pc + 32'd4, "jal link");
        check_store(1, 32'h404, jalr_pc + 32'd4, "jalr link");
        check_store(2, 32'h408, {upper_lui, 12'b0}, "lui");
        check_store(3, 32'h40c, auipc_pc + {upper_auipc, 12'b0}, "auipc");
    endtask

    task automatic swap_mscratch();
        word_t first;
        clear_image();
        draw_bits(32, first);
        emit(i_type(12'h400, 5'd0, 3'b000, 5'd1, OP_IMM));
        load_const(5'd2, first);
        emit(i_type(`RV_CSR_MSCRATCH, 5'd2, 3'b001, 5'd3, OP_SYSTEM));
        emit(s_type(12'd0, 5'd3, 5'd1));
        emit(i_type(12'h123, 5'd0, 3'b000, 5'd4, OP_IMM));
        emit(i_type(`RV_CSR_MSCRATCH, 5'd4, 3'b001, 5'd5, OP_SYSTEM));
        emit(s_type(12'd4, 5'd5, 5'd1));
        // mepc is not implemented.
        emit(i_type(12'h341, 5'd2, 3'b001, 5'd6, OP_SYSTEM));
        emit(s_type(12'd8, 5'd6, 5'd1));
        emit(i_type(`RV_CSR_MSCRATCH, 5'd0, 3'b001, 5'd7, OP_SYSTEM));
        emit(s_type(12'd12, 5'd7, 5'd1));
        emit(j_type(21'd0, 5'd0));
        reset_and_load();
        wait_for_stores(4);
        check_store(0, 32'h400, 32'h0, "first csrrw");
        check_store(1, 32'h404, first, "second csrrw");
        check_store(2, 32'h408, 32'h0, "csrrw on mepc");
        check_store(3, 32'h40c, 32'h123, "mscratch after mepc write");
    endtask

    task automatic discard_x0_writes();
        clear_image();
        emit(i_type(12'h400, 5'd0, 3'b000, 5'd1, OP_IMM));
        emit(i_type(12'd77, 5'd0, 3'b000, 5'd2, OP_IMM));
        emit(r_type(7'b0000000, 5'd2, 5'd2, 3'b000, 5'd0));
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd0, OP_IMM));
        emit(s_type(12'd0, 5'd0, 5'd1));
        emit(r_type(7'b0000000, 5'd2, 5'd0, 3'b000, 5'd3));
        emit(s_type(12'd4, 5'd3, 5'd1));
        emit(j_type(21'd0, 5'd0));
        reset_and_load();
        wait_for_stores(2);
        check_store(0, 32'h400, 32'h0, "x0 after writes");
        check_store(1, 32'h404, 32'd77, "add from x0");
    endtask

    task automatic finish_run();
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        timeout_count++;
        $display("timeout: the tests did not finish within %0d cycles", cycle_count);
        finish_run();
    end

    initial begin
        reset     = 1'b1;
        mem_rdata = '0;
        exercise_alu();
        round_trip_memory();
        branch_on_equal();
        jumps_and_upper();
        swap_mscratch();
        discard_x0_writes();
        finish_run();
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/alu.sv
verilog/imm_gen.sv
verilog/register_file.sv
verilog/csr_unit.sv
verilog/control_unit.sv
verilog/rv_multicycle_core.sv
sim/rv_multicycle_core_chk.sv
sim/rv_multicycle_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
    --top-module rv_multicycle_core_tb -o rv_sim

output=$(./obj_dir/rv_sim) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "simulation did not report a pass" >&2
exit 1
